// ==== logic/cmd_credit_port.sv ====
// drawing engine command port
// sender side of a credit-based link; commands without a credit are dropped

`timescale 1ns/100ps
`default_nettype none

module cmd_credit_port import io_pkg::*; (
    input  wire logic              clk_cpu,
    input  wire logic              rst_n,
    input  wire logic              push_i,
    input  wire logic [DATA_W-1:0] data_i,
    input  wire logic              credit_return_i,
    output      cmd_beat_t         cmd_o,
    output      logic              credit_avail_o,
    output      logic              drop_o
);

    logic [CMD_CREDIT_W-1:0] credit_q;
    logic                    beat_valid_q;
    logic [DATA_W-1:0]       beat_data_q;
    logic                    send;
    logic                    credit_full;

    assign credit_avail_o = (credit_q != '0);
    assign credit_full    = (credit_q == CMD_CREDIT_W'(CMD_CREDITS));
    assign send           = push_i && credit_avail_o;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            credit_q     <= CMD_CREDIT_W'(CMD_CREDITS);
            beat_valid_q <= 1'b0;
            drop_o       <= 1'b0;
        end else begin
            beat_valid_q <= send; // one-cycle beat
            if (send && !credit_return_i) begin
                credit_q <= credit_q - 1'b1;
            end else if (!send && credit_return_i && !credit_full) begin
                credit_q <= credit_q + 1'b1; // never above the initial count
            end
            if (push_i && !credit_avail_o) begin
                drop_o <= 1'b1; // sticky, command lost
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (send) begin
            beat_data_q <= data_i;
        end
    end

    assign cmd_o = '{valid: beat_valid_q, data: beat_data_q};

endmodule

`default_nettype wire

// ==== logic/io_pkg.sv ====
// I/O block shared definitions
// register map, sizes and processor/command bus structs

`default_nettype none

package io_pkg;

    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int LED_W      = 8;
    localparam int RX_BYTE_W  = 8;

    localparam logic [3:0] IO_BASE_NIBBLE = 4'hE; // top address nibble for I/O

    localparam int CYCLES_PER_MS = 25000; // clk_cpu at 25 MHz
    localparam int MS_PRESC_W    = $clog2(CYCLES_PER_MS);

    localparam int RX_DEPTH = 16;
    localparam int RX_PTR_W = $clog2(RX_DEPTH);

    localparam int CMD_CREDITS  = 4; // drawing engine input slots
    localparam int CMD_CREDIT_W = $clog2(CMD_CREDITS + 1);

    // word index, address bits 5:2
    typedef enum logic [3:0] {
        REG_MS      = 4'd0,
        REG_LED     = 4'd1,
        REG_RX_DATA = 4'd2,
        REG_RX_STAT = 4'd3,
        REG_CMD     = 4'd8
    } io_reg_e;

    typedef struct packed {
        logic              sel;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } io_req_t;

    typedef struct packed {
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } io_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } cmd_beat_t;

endpackage

`default_nettype wire

// ==== logic/io_regs.sv ====
// I/O register file
// decodes the processor bus at the I/O base, holds the LEDs and registers read data

`timescale 1ns/100ps
`default_nettype none

module io_regs import io_pkg::*; (
    input  wire logic                 clk_cpu,
    input  wire logic                 rst_n,
    input  wire io_req_t              req_i,
    input  wire logic [DATA_W-1:0]    ms_count_i,
    input  wire logic                 rx_nonempty_i,
    input  wire logic                 rx_overflow_i,
    input  wire logic [RX_BYTE_W-1:0] rx_byte_i,
    input  wire logic                 cmd_credit_avail_i,
    input  wire logic                 cmd_drop_i,
    output      io_rsp_t              rsp_o,
    output      logic [LED_W-1:0]     led_o,
    output      logic                 rx_pop_o,
    output      logic                 cmd_push_o,
    output      logic [DATA_W-1:0]    cmd_data_o
);

    io_reg_e           word;
    logic              io_hit;
    logic              io_wr;
    logic              io_rd;
    logic [DATA_W-1:0] rdata_d;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;

    assign io_hit = req_i.sel && (req_i.addr[ADDR_W-1:ADDR_W-4] == IO_BASE_NIBBLE);
    assign word   = io_reg_e'(req_i.addr[5:2]); // word index
    assign io_wr  = io_hit && req_i.we;
    assign io_rd  = io_hit && !req_i.we;

    // strobes go straight out, the target blocks check empty / credit
    assign rx_pop_o   = io_wr && (word == REG_RX_STAT);
    assign cmd_push_o = io_wr && (word == REG_CMD);
    assign cmd_data_o = req_i.wdata;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o <= '0;
        end else if (io_wr && (word == REG_LED)) begin
            led_o <= req_i.wdata[LED_W-1:0];
        end
    end

    // read mux, unmapped words return zero
    always_comb begin
        rdata_d = '0;
        case (word)
            REG_MS:      rdata_d = ms_count_i;
            REG_LED:     rdata_d = '0; // write-only
            REG_RX_DATA: rdata_d = {{(DATA_W - RX_BYTE_W){1'b0}}, rx_byte_i};
            REG_RX_STAT: rdata_d = {{(DATA_W - 2){1'b0}}, rx_overflow_i, rx_nonempty_i};
            REG_CMD:     rdata_d = {{(DATA_W - 2){1'b0}}, cmd_drop_i, cmd_credit_avail_i};
            default:     rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= io_rd; // one cycle after the request
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (io_rd) begin
            rdata_q <= rdata_d;
        end
    end

    assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== logic/io_subsystem.sv ====
// memory-mapped I/O subsystem
// ms timer, LEDs, serial receive queue and drawing engine command port on one bus

`timescale 1ns/100ps
`default_nettype none

module io_subsystem import io_pkg::*; (
    input  wire logic                 clk_cpu,
    input  wire logic                 rst_n,
    input  wire io_req_t              req_i,
    output      io_rsp_t              rsp_o,
    output      logic [LED_W-1:0]     led_o,
    input  wire logic                 rx_valid_i,
    input  wire logic [RX_BYTE_W-1:0] rx_data_i,
    output      cmd_beat_t            cmd_o,
    input  wire logic                 credit_return_i
);

    logic [DATA_W-1:0]    ms_count;
    logic                 rx_nonempty;
    logic                 rx_overflow;
    logic [RX_BYTE_W-1:0] rx_byte;
    logic                 rx_pop;
    logic                 cmd_push;
    logic [DATA_W-1:0]    cmd_data;
    logic                 cmd_credit_avail;
    logic                 cmd_drop;

    io_regs u_io_regs (
        .clk_cpu            (clk_cpu),
        .rst_n              (rst_n),
        .req_i              (req_i),
        .ms_count_i         (ms_count),
        .rx_nonempty_i      (rx_nonempty),
        .rx_overflow_i      (rx_overflow),
        .rx_byte_i          (rx_byte),
        .cmd_credit_avail_i (cmd_credit_avail),
        .cmd_drop_i         (cmd_drop),
        .rsp_o              (rsp_o),
        .led_o              (led_o),
        .rx_pop_o           (rx_pop),
        .cmd_push_o         (cmd_push),
        .cmd_data_o         (cmd_data)
    );

    ms_timer u_ms_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    rx_byte_queue u_rx_byte_queue (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .rx_valid_i (rx_valid_i),
        .rx_data_i  (rx_data_i),
        .pop_i      (rx_pop),
        .nonempty_o (rx_nonempty),
        .overflow_o (rx_overflow),
        .byte_o     (rx_byte)
    );

    cmd_credit_port u_cmd_credit_port (
        .clk_cpu         (clk_cpu),
        .rst_n           (rst_n),
        .push_i          (cmd_push),
        .data_i          (cmd_data),
        .credit_return_i (credit_return_i),
        .cmd_o           (cmd_o),
        .credit_avail_o  (cmd_credit_avail),
        .drop_o          (cmd_drop)
    );

endmodule

`default_nettype wire

// ==== logic/ms_timer.sv ====
// millisecond timer
// prescales clk_cpu down to 1 ms and keeps a free running ms count

`timescale 1ns/100ps
`default_nettype none

module ms_timer import io_pkg::*; (
    input  wire logic              clk_cpu,
    input  wire logic              rst_n,
    output      logic [DATA_W-1:0] ms_count_o
);

    logic [MS_PRESC_W-1:0] presc_q;
    logic                  presc_wrap;

    assign presc_wrap = (presc_q == MS_PRESC_W'(CYCLES_PER_MS - 1)); // last cycle of the ms

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            presc_q    <= '0;
            ms_count_o <= '0;
        end else begin
            if (presc_wrap) begin
                presc_q    <= '0;
                ms_count_o <= ms_count_o + 1'b1; // wraps after ~49 days
            end else begin
                presc_q <= presc_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rx_byte_queue.sv ====
// serial receive byte queue
// circular FIFO that drops bytes when full, plus a holding register for the popped byte

`timescale 1ns/100ps
`default_nettype none

module rx_byte_queue import io_pkg::*; (
    input  wire logic                 clk_cpu,
    input  wire logic                 rst_n,
    input  wire logic                 rx_valid_i,
    input  wire logic [RX_BYTE_W-1:0] rx_data_i,
    input  wire logic                 pop_i,
    output      logic                 nonempty_o,
    output      logic                 overflow_o,
    output      logic [RX_BYTE_W-1:0] byte_o
);

    logic [RX_BYTE_W-1:0] mem [RX_DEPTH];
    logic [RX_PTR_W-1:0]  wr_ptr_q;
    logic [RX_PTR_W-1:0]  rd_ptr_q;
    logic [RX_PTR_W:0]    count_q;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full       = (count_q == (RX_PTR_W + 1)'(RX_DEPTH));
    assign push       = rx_valid_i && !full;  // no back-pressure toward the receiver
    assign pop        = pop_i && (count_q != '0);
    assign nonempty_o = (count_q != '0);

    always_ff @(posedge clk_cpu) begin
        if (push) begin
            mem[wr_ptr_q] <= rx_data_i;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_o <= 1'b0;
            byte_o     <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
                byte_o   <= mem[rd_ptr_q];   // head into holding reg
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            if (rx_valid_i && full) begin
                overflow_o <= 1'b1; // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/io_checker.sv ====
// I/O subsystem output checker
// compares read data, LED state and command beats against the testbench model

`timescale 1ns/100ps
`default_nettype none

module io_checker import io_pkg::*; (
    input wire logic             clk_cpu,
    input wire logic             rst_n,
    input wire io_rsp_t          rsp_i,
    input wire logic [LED_W-1:0] led_i,
    input wire cmd_beat_t        cmd_i
);

    typedef struct packed {
        int                due;  // falling edge where the value must show
        logic [DATA_W-1:0] data;
    } exp_t;

    int               error_count = 0;
    int               edge_cnt    = 0;
    exp_t             rd_q[$];
    exp_t             beat_q[$];
    exp_t             cur;
    exp_t             led_next    = '0;
    logic [LED_W-1:0] led_exp     = '0;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp, got);
        $display("ERROR %s expected %h got %h", name, exp, got);
        error_count++;
    endtask

    // outputs change one cycle after the access and show at the second falling edge
    task automatic expect_read(input logic [DATA_W-1:0] data);
        rd_q.push_back({edge_cnt + 2, data});
    endtask

    task automatic expect_beat(input logic [DATA_W-1:0] data);
        beat_q.push_back({edge_cnt + 2, data});
    endtask

    task automatic expect_led(input logic [LED_W-1:0] led);
        led_next = {edge_cnt + 2, DATA_W'(led)};
    endtask

    always @(negedge clk_cpu) begin
        edge_cnt = edge_cnt + 1;
        if (rst_n) begin
            if (edge_cnt >= led_next.due) led_exp = led_next.data[LED_W-1:0];
            if (led_i !== led_exp) report_mismatch("led_o", led_exp, led_i);
            if (rd_q.size() > 0 && rd_q[0].due < edge_cnt) begin
                cur = rd_q.pop_front();
                report_failure("read request got no response in time");
            end
            if (rsp_i.rvalid) begin
                if (rd_q.size() == 0 || rd_q[0].due != edge_cnt) begin
                    report_failure("read response without a matching request");
                end else begin
                    cur = rd_q.pop_front();
                    if (rsp_i.rdata !== cur.data) begin
                        report_mismatch("rsp_o.rdata", cur.data, rsp_i.rdata);
                    end
                end
            end
            if (beat_q.size() > 0 && beat_q[0].due < edge_cnt) begin
                cur = beat_q.pop_front();
                report_failure("command write never showed up on cmd_o");
            end
            if (cmd_i.valid) begin
                if (beat_q.size() == 0 || beat_q[0].due != edge_cnt) begin
                    report_failure("command beat on cmd_o that was not expected");
                end else begin
                    cur = beat_q.pop_front();
                    if (cmd_i.data !== cur.data) begin
                        report_mismatch("cmd_o.data", cur.data, cmd_i.data);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/io_tb.sv ====
// testbench top for the I/O subsystem
// drives bus, serial bytes and credits while a reference model predicts the results

`timescale 1ns/100ps
`default_nettype none

module io_tb import io_pkg::*; ();

    logic                 clk_cpu;
    logic                 rst_n;
    io_req_t              req;
    io_rsp_t              rsp;
    logic [LED_W-1:0]     led;
    logic                 rx_valid;
    logic [RX_BYTE_W-1:0] rx_data;
    cmd_beat_t            cmd;
    logic                 credit_return;
    integer               seed                 = 8;
    int                   cycles_since_release = 0;
    logic [RX_BYTE_W-1:0] exp_fifo[$];
    logic [RX_BYTE_W-1:0] exp_hold             = '0;
    logic                 exp_ovf              = 1'b0;
    int                   exp_credits          = CMD_CREDITS;
    logic                 exp_drop             = 1'b0;

    tb_clk_gen u_tb_clk_gen (.clk_o(clk_cpu), .rst_n_o(rst_n));

    io_subsystem u_io_subsystem (
        .clk_cpu         (clk_cpu),
        .rst_n           (rst_n),
        .req_i           (req),
        .rsp_o           (rsp),
        .led_o           (led),
        .rx_valid_i      (rx_valid),
        .rx_data_i       (rx_data),
        .cmd_o           (cmd),
        .credit_return_i (credit_return)
    );

    io_checker u_io_checker (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .rsp_i   (rsp),
        .led_i   (led),
        .cmd_i   (cmd)
    );

    always @(negedge clk_cpu) begin
        if (rst_n) cycles_since_release = cycles_since_release + 1;
    end

    function automatic logic [DATA_W-1:0] expected_ms(input int cycles);
        return DATA_W'(cycles / CYCLES_PER_MS);
    endfunction

    function automatic logic [DATA_W-1:0] rx_status(input logic nonempty, input logic ovf);
        return {30'b0, ovf, nonempty};
    endfunction

    function automatic logic [DATA_W-1:0] cmd_status(input int credits, input logic drop);
        return {30'b0, drop, credits != 0};
    endfunction

    function automatic logic [ADDR_W-1:0] io_addr(input logic [3:0] word);
        return {IO_BASE_NIBBLE, 22'b0, word, 2'b00};
    endfunction

    task automatic start_access(input logic we, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data);
        @(posedge clk_cpu);
        req <= {1'b1, we, addr, data};
    endtask

    task automatic end_access();
        @(posedge clk_cpu);
        req <= '0;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        start_access(1'b1, addr, data);
        if (addr[31:28] == IO_BASE_NIBBLE) begin
            case (addr[5:2])
                REG_LED:     u_io_checker.expect_led(data[LED_W-1:0]);
                REG_RX_STAT: if (exp_fifo.size() > 0) exp_hold = exp_fifo.pop_front();
                REG_CMD: begin
                    if (exp_credits > 0) begin
                        exp_credits--;
                        u_io_checker.expect_beat(data);
                    end else begin
                        exp_drop = 1'b1; // no credit so the command is lost
                    end
                end
                default: ;
            endcase
        end
        end_access();
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] exp;
        logic              got;
        int                t;
        got = 1'b0;
        start_access(1'b0, addr, '0);
        if (addr[31:28] != IO_BASE_NIBBLE) begin
            end_access();
            repeat (3) @(negedge clk_cpu); // checker flags any stray rvalid
        end else begin
            case (addr[5:2])
                REG_MS:      exp = expected_ms(cycles_since_release);
                REG_RX_DATA: exp = {24'b0, exp_hold};
                REG_RX_STAT: exp = rx_status(exp_fifo.size() != 0, exp_ovf);
                REG_CMD:     exp = cmd_status(exp_credits, exp_drop);
                default:     exp = '0; // LED and unmapped words read zero
            endcase
            u_io_checker.expect_read(exp);
            end_access();
            for (t = 0; t < 8 && !got; t++) begin
                @(negedge clk_cpu);
                got = rsp.rvalid;
            end
            if (!got) u_io_checker.report_failure("timeout waiting for a read response");
        end
    endtask

    // REG_MS read whose request cycle lands on the given cycle count
    task automatic read_ms_at(input int cycles);
        int t;
        for (t = 0; t < 2 * CYCLES_PER_MS && cycles_since_release < cycles - 1; t++) begin
            @(posedge clk_cpu);
        end
        if (cycles_since_release < cycles - 1) begin
            u_io_checker.report_failure("timeout waiting for the ms sample point");
        end
        bus_read(io_addr(REG_MS));
    endtask

    task automatic push_byte(input logic [RX_BYTE_W-1:0] b);
        @(posedge clk_cpu);
        rx_valid <= 1'b1;
        rx_data  <= b;
        if (exp_fifo.size() < RX_DEPTH) exp_fifo.push_back(b);
        else exp_ovf = 1'b1;
        @(posedge clk_cpu);
        rx_valid <= 1'b0;
    endtask

    task automatic pop_and_read();
        bus_write(io_addr(REG_RX_STAT), '0);
        bus_read(io_addr(REG_RX_DATA));
    endtask

    task automatic return_credit();
        @(posedge clk_cpu);
        credit_return <= 1'b1;
        if (exp_credits < CMD_CREDITS) exp_credits++;
        @(posedge clk_cpu);
        credit_return <= 1'b0;
    endtask

    initial begin
        int                t;
        logic [DATA_W-1:0] val;
        req           <= '0;
        rx_valid      <= 1'b0;
        rx_data       <= '0;
        credit_return <= 1'b0;
        for (t = 0; t < 20 && rst_n !== 1'b1; t++) @(posedge clk_cpu);
        if (rst_n !== 1'b1) u_io_checker.report_failure("reset was never released");
        bus_read(io_addr(REG_RX_STAT)); // state right after reset
        bus_read(io_addr(REG_CMD));
        val = $random(seed);
        bus_write(io_addr(REG_LED), val);
        bus_read(io_addr(REG_LED));
        for (t = 0; t < 5; t++) push_byte($random(seed));
        bus_read(io_addr(REG_RX_STAT));
        for (t = 0; t < 5; t++) pop_and_read();
        bus_read(io_addr(REG_RX_STAT));
        pop_and_read(); // pop on an empty queue keeps the holding byte
        for (t = 0; t < RX_DEPTH + 3; t++) push_byte($random(seed));
        bus_read(io_addr(REG_RX_STAT));
        for (t = 0; t < RX_DEPTH; t++) pop_and_read();
        bus_read(io_addr(REG_RX_STAT));
        for (t = 0; t <= CMD_CREDITS; t++) begin
            bus_write(io_addr(REG_CMD), $random(seed)); // last one has no credit
            bus_read(io_addr(REG_CMD));
        end
        return_credit();
        bus_write(io_addr(REG_CMD), $random(seed));
        bus_read(io_addr(REG_CMD));
        bus_read(io_addr(4'd5));
        bus_read(32'hA000_0004); // LED word outside the I/O space
        bus_write(32'hA000_0004, ~val);
        // ms count on both sides of each boundary
        read_ms_at(CYCLES_PER_MS - 1);
        read_ms_at(CYCLES_PER_MS + 1);
        read_ms_at(2 * CYCLES_PER_MS - 2);
        read_ms_at(2 * CYCLES_PER_MS);
        read_ms_at(3 * CYCLES_PER_MS - 1);
        read_ms_at(3 * CYCLES_PER_MS + 1);
        repeat (4) @(posedge clk_cpu);
        $display("checks complete, %0d errors", u_io_checker.error_count);
        if (u_io_checker.error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
// testbench clock and reset
// 4 ns clk_cpu, rst_n held low for the first 5 cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // 250 MHz sim clock, period only matters in cycles
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/io_pkg.sv
logic/ms_timer.sv
logic/rx_byte_queue.sv
logic/cmd_credit_port.sv
logic/io_regs.sv
logic/io_subsystem.sv
verification/tb_clk_gen.sv
verification/io_checker.sv
verification/io_tb.sv
